// ==== amiga_io_pkg.sv ====
////////////////////
// types shared by the clk_sys io glue
// stereo structs carry left in the upper half
// option flags are stored at their bus bit positions
////////////////////

package amiga_io_pkg;

	////////////////////
	// bridge bus
	typedef logic [31:0] bus_addr_t;	// word address
	typedef logic [31:0] bus_data_t;

	////////////////////
	// controllers
	// host key bitmap [3:0] up down left right, [7:4] a b x y
	// [8] l1, [9] r1, [14] select
	typedef logic [31:0] cont_key_t;
	typedef logic [15:0] amiga_joy_t;	// active low

	// cpu bus phase divider, one frame is 16 clocks
	typedef logic [3:0] phase_div_t;

	////////////////////
	// audio
	typedef logic [14:0] paula_raw_t;	// 15 bit paula sample
	typedef logic [8:0]  paula_pwm_t;	// pwm volume sample
	typedef logic [15:0] audio_word_t;

	typedef struct packed {
		paula_raw_t left;
		paula_raw_t right;
	} stereo_raw_t;

	typedef struct packed {
		paula_pwm_t left;
		paula_pwm_t right;
	} stereo_pwm_t;

	typedef struct packed {
		audio_word_t left;
		audio_word_t right;
	} stereo_out_t;

	typedef struct packed {
		logic paula_pwm;	// use the pwm volume samples
		logic joy1_off;
		logic joy2_off;
	} core_opts_t;

	// bus bit positions of the option flags
	localparam int OPT_BIT_PWM  = 3;
	localparam int OPT_BIT_JOY1 = 4;
	localparam int OPT_BIT_JOY2 = 5;

endpackage

// ==== core_opts_regs.sv ====
////////////////////
// core option register on plain bus strobes
// one word address, only bits 3 to 5 are stored
// writes take effect at the strobe edge, no wait states
////////////////////

`timescale 1ns/1ps

module core_opts_regs import amiga_io_pkg::*; #(
	parameter bus_addr_t OPT_ADDR = 32'hF000_0000
) (
	input  logic       clk_sys,
	input  logic       cpu_rst,
	input  logic       bus_wr,
	input  logic       bus_rd,
	input  bus_addr_t  bus_addr,
	input  bus_data_t  bus_wdata,
	output bus_data_t  bus_rdata,
	output core_opts_t opts
);

	logic addr_hit;
	logic wr_hit;
	logic rd_hit;

	assign addr_hit = (bus_addr == OPT_ADDR);
	assign wr_hit   = bus_wr & addr_hit;
	assign rd_hit   = bus_rd & addr_hit;

	////////////////////
	// storage

	always_ff @(posedge clk_sys) begin
		if (!cpu_rst) begin
			opts <= '0;	// all options off
		end else if (wr_hit) begin
			opts.paula_pwm <= bus_wdata[OPT_BIT_PWM];
			opts.joy1_off  <= bus_wdata[OPT_BIT_JOY1];
			opts.joy2_off  <= bus_wdata[OPT_BIT_JOY2];
		end
	end

	////////////////////
	// readback

	// reserved bits read as zero
	always_comb begin
		bus_rdata = '0;
		if (rd_hit) begin
			bus_rdata[OPT_BIT_PWM]  = opts.paula_pwm;
			bus_rdata[OPT_BIT_JOY1] = opts.joy1_off;
			bus_rdata[OPT_BIT_JOY2] = opts.joy2_off;
		end
	end

endmodule

// ==== joy_mapper.sv ====
////////////////////
// host key bitmap to amiga joystick word
// key input may be asynchronous to clk_sys
// SYNC_STAGES must be 1 or more
// output is active low and all ones while off is set
////////////////////

`timescale 1ns/1ps

module joy_mapper import amiga_io_pkg::*; #(
	parameter int SYNC_STAGES = 3
) (
	input  logic       clk_sys,
	input  logic       cpu_rst,
	input  cont_key_t  key,
	input  logic       off,
	output amiga_joy_t joy
);

	cont_key_t  sync_q [SYNC_STAGES];
	cont_key_t  key_s;
	amiga_joy_t joy_act;	// active high before inversion

	////////////////////
	// synchroniser

	always_ff @(posedge clk_sys) begin
		if (!cpu_rst) begin
			for (int i = 0; i < SYNC_STAGES; i++) begin
				sync_q[i] <= '0;
			end
		end else begin
			sync_q[0] <= key;
			for (int i = 1; i < SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	assign key_s = sync_q[SYNC_STAGES-1];

	////////////////////
	// bit mapping

	// amiga order is fire4..fire, up, down, left, right
	always_comb begin
		joy_act = '0;
		if (!off) begin
			joy_act[10] = key_s[14];	// select
			joy_act[9]  = key_s[9];	// r1
			joy_act[8]  = key_s[8];	// l1
			joy_act[7]  = key_s[7];	// y
			joy_act[6]  = key_s[6];	// x
			joy_act[5]  = key_s[5];	// b
			joy_act[4]  = key_s[4];	// a, main fire
			joy_act[3]  = key_s[0];	// up
			joy_act[2]  = key_s[1];	// down
			joy_act[1]  = key_s[2];	// left
			joy_act[0]  = key_s[3];	// right
		end
	end

	assign joy = ~joy_act;

endmodule

// ==== cpu_phase_gen.sv ====
////////////////////
// cpu bus cycle and phase strobes
// c1 must already be synchronous to clk_sys
// every c1 rising edge re-aligns the 16 clock frame
////////////////////

`timescale 1ns/1ps

module cpu_phase_gen import amiga_io_pkg::*; (
	input  logic clk_sys,
	input  logic cpu_rst,
	input  logic c1,
	output logic cyc,
	output logic ph1,
	output logic ph2
);

	phase_div_t div_q;
	logic       c1_q;
	logic       c1_rise;

	assign c1_rise = c1 & ~c1_q;	// c1 high now, low last clock

	////////////////////
	// divider

	always_ff @(posedge clk_sys) begin
		if (!cpu_rst) begin
			div_q <= '0;
			c1_q  <= 1'b0;
		end else begin
			c1_q <= c1;
			if (c1_rise) begin
				div_q <= phase_div_t'(3);	// lines up with the chipset slot
			end else begin
				div_q <= div_q + 1'b1;
			end
		end
	end

	////////////////////
	// strobes

	always_ff @(posedge clk_sys) begin
		if (!cpu_rst) begin
			cyc <= 1'b0;
			ph1 <= 1'b0;
			ph2 <= 1'b0;
		end else begin
			cyc <= (div_q[1:0] == 2'd0);	// once every 4 clocks
			// phases only change in slot 2 of each quarter
			if (div_q[1:0] == 2'd2) begin
				ph1 <= (div_q[3:2] == 2'd2);
				ph2 <= (div_q[3:2] == 2'd0);
			end
		end
	end

endmodule

// ==== paula_audio_out.sv ====
////////////////////
// paula sample format select and settle filter
// a sample must be stable for two clocks to be taken
// audio lags a stable input by four clocks
////////////////////

`timescale 1ns/1ps

module paula_audio_out import amiga_io_pkg::*; (
	input  logic        clk_sys,
	input  logic        cpu_rst,
	input  logic        pwm_sel,
	input  stereo_raw_t raw,
	input  stereo_pwm_t okk,
	output stereo_out_t audio
);

	localparam int NCH = 2;	// 0 left, 1 right

	audio_word_t smp_sel [NCH];
	audio_word_t smp0_q  [NCH];	// first copy
	audio_word_t smp1_q  [NCH];	// second copy
	audio_word_t hold_q  [NCH];
	audio_word_t out_q   [NCH];

	////////////////////
	// format select

	// both forms left justified into 16 bits
	always_comb begin
		if (pwm_sel) begin
			smp_sel[0] = {okk.left, 7'b0};
			smp_sel[1] = {okk.right, 7'b0};
		end else begin
			smp_sel[0] = {raw.left, 1'b0};
			smp_sel[1] = {raw.right, 1'b0};
		end
	end

	////////////////////
	// settle filter and output register

	always_ff @(posedge clk_sys) begin
		if (!cpu_rst) begin
			for (int ch = 0; ch < NCH; ch++) begin
				smp0_q[ch] <= '0;
				smp1_q[ch] <= '0;
				hold_q[ch] <= '0;
				out_q[ch]  <= '0;
			end
		end else begin
			for (int ch = 0; ch < NCH; ch++) begin
				smp0_q[ch] <= smp_sel[ch];
				smp1_q[ch] <= smp0_q[ch];
				// glitches between chipset updates never reach the output
				if (smp0_q[ch] == smp1_q[ch]) begin
					hold_q[ch] <= smp1_q[ch];
				end
				out_q[ch] <= hold_q[ch];
			end
		end
	end

	assign audio.left  = out_q[0];
	assign audio.right = out_q[1];

endmodule

// ==== amiga_io_top.sv ====
////////////////////
// clk_sys io glue top
// option register, two joystick ports, cpu phases, audio out
// all inputs are sampled every clock, no back-pressure
////////////////////

`timescale 1ns/1ps

module amiga_io_top import amiga_io_pkg::*; #(
	parameter bus_addr_t OPT_ADDR    = 32'hF000_0000,
	parameter int        SYNC_STAGES = 3
) (
	input  logic        clk_sys,
	input  logic        cpu_rst,
	// bridge strobes
	input  logic        bus_wr,
	input  logic        bus_rd,
	input  bus_addr_t   bus_addr,
	input  bus_data_t   bus_wdata,
	output bus_data_t   bus_rdata,
	// controllers
	input  cont_key_t   cont1_key,
	input  cont_key_t   cont2_key,
	output amiga_joy_t  joy1,
	output amiga_joy_t  joy2,
	// cpu bus timing
	input  logic        c1,
	output logic        cyc,
	output logic        ph1,
	output logic        ph2,
	// audio
	input  stereo_raw_t paula_raw,
	input  stereo_pwm_t paula_okk,
	output stereo_out_t audio
);

	core_opts_t opts;

	core_opts_regs #(
		.OPT_ADDR (OPT_ADDR)
	) u_opts (
		.clk_sys   (clk_sys),
		.cpu_rst   (cpu_rst),
		.bus_wr    (bus_wr),
		.bus_rd    (bus_rd),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_rdata (bus_rdata),
		.opts      (opts)
	);

	////////////////////
	// joystick ports

	joy_mapper #(
		.SYNC_STAGES (SYNC_STAGES)
	) u_joy1 (
		.clk_sys (clk_sys),
		.cpu_rst (cpu_rst),
		.key     (cont1_key),
		.off     (opts.joy1_off),	// mouse port
		.joy     (joy1)
	);

	joy_mapper #(
		.SYNC_STAGES (SYNC_STAGES)
	) u_joy2 (
		.clk_sys (clk_sys),
		.cpu_rst (cpu_rst),
		.key     (cont2_key),
		.off     (opts.joy2_off),	// default joystick port
		.joy     (joy2)
	);

	cpu_phase_gen u_phase (
		.clk_sys (clk_sys),
		.cpu_rst (cpu_rst),
		.c1      (c1),
		.cyc     (cyc),
		.ph1     (ph1),
		.ph2     (ph2)
	);

	paula_audio_out u_audio (
		.clk_sys (clk_sys),
		.cpu_rst (cpu_rst),
		.pwm_sel (opts.paula_pwm),
		.raw     (paula_raw),
		.okk     (paula_okk),
		.audio   (audio)
	);

endmodule

// ==== tb_amiga_io_top.sv ====
////////////////////
// directed testbench for the clk_sys io glue
// inputs change just after the rising edge, outputs are sampled on the falling edge
// stops at the first mismatch
////////////////////

`timescale 1ns/1ps

module tb_amiga_io_top import amiga_io_pkg::*;;

	localparam int        CLK_PERIOD    = 20;
	localparam int        RESET_CYCLES  = 16;
	localparam int        RAND_SEED     = 32'h3854;
	localparam bus_addr_t OPT_ADDR      = 32'hF000_0000;
	localparam bus_data_t OPT_MASK      = 32'h0000_0038;	// bits 3 to 5
	localparam bus_data_t PWM_ON        = 32'h0000_0008;
	localparam bus_data_t JOY1_OFF      = 32'h0000_0010;
	localparam bus_data_t JOY2_OFF      = 32'h0000_0020;
	localparam int        OPT_WRITES    = 8;
	localparam int        JOY_KEYS      = 8;
	localparam int        PHASE_CYCLES  = 48;
	localparam int        AUDIO_SAMPLES = 4;
	localparam int        TOGGLE_CYCLES = 12;
	// rough cycle cost of every test added up
	localparam int TEST_CYCLES = RESET_CYCLES + 4 + OPT_WRITES * 12 + JOY_KEYS * 6 + 24
		+ PHASE_CYCLES + 8 + AUDIO_SAMPLES * 8 + TOGGLE_CYCLES + 24;
	localparam int WATCHDOG_NS = TEST_CYCLES * 2 * CLK_PERIOD;

	logic        clk_sys;
	logic        cpu_rst;
	logic        bus_wr;
	logic        bus_rd;
	bus_addr_t   bus_addr;
	bus_data_t   bus_wdata;
	bus_data_t   bus_rdata;
	cont_key_t   cont1_key;
	cont_key_t   cont2_key;
	amiga_joy_t  joy1;
	amiga_joy_t  joy2;
	logic        c1;
	logic        cyc;
	logic        ph1;
	logic        ph2;
	stereo_raw_t paula_raw;
	stereo_pwm_t paula_okk;
	stereo_out_t audio;

	string       cur_test;
	int          err_count;
	int unsigned seed_val;

	amiga_io_top #(
		.OPT_ADDR    (OPT_ADDR),
		.SYNC_STAGES (3)
	) UUT (
		.clk_sys   (clk_sys),
		.cpu_rst   (cpu_rst),
		.bus_wr    (bus_wr),
		.bus_rd    (bus_rd),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_rdata (bus_rdata),
		.cont1_key (cont1_key),
		.cont2_key (cont2_key),
		.joy1      (joy1),
		.joy2      (joy2),
		.c1        (c1),
		.cyc       (cyc),
		.ph1       (ph1),
		.ph2       (ph2),
		.paula_raw (paula_raw),
		.paula_okk (paula_okk),
		.audio     (audio)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	////////////////////
	// reference models

	// active high word is select r1 l1 y x b a, then up down left right
	function automatic amiga_joy_t joy_word(cont_key_t k, logic off);
		amiga_joy_t w;
		w = '0;
		if (!off) begin
			w[10:0] = {k[14], k[9], k[8], k[7], k[6], k[5], k[4], k[0], k[1], k[2], k[3]};
		end
		return ~w;
	endfunction

	function automatic stereo_out_t raw_form(stereo_raw_t r);
		stereo_out_t s;
		s.left  = {r.left, 1'b0};
		s.right = {r.right, 1'b0};
		return s;
	endfunction

	function automatic stereo_out_t pwm_form(stereo_pwm_t p);
		stereo_out_t s;
		s.left  = {p.left, 7'b0};
		s.right = {p.right, 7'b0};
		return s;
	endfunction

	////////////////////
	// compare tasks

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_data(input string what, input bus_data_t exp, input bus_data_t act);
		if (exp !== act) begin
			err_count++;
			abort_run($sformatf("[FAIL] %s %s expected %h actual %h", cur_test, what, exp, act));
		end
	endtask

	task automatic check_joy(input string what, input amiga_joy_t exp, input amiga_joy_t act);
		if (exp !== act) begin
			err_count++;
			abort_run($sformatf("[FAIL] %s %s expected %h actual %h", cur_test, what, exp, act));
		end
	endtask

	task automatic check_audio(input string what, input stereo_out_t exp,
		input stereo_out_t act);
		if (exp !== act) begin
			err_count++;
			abort_run($sformatf("[FAIL] %s %s expected %h actual %h", cur_test, what, exp, act));
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (exp !== act) begin
			err_count++;
			abort_run($sformatf("[FAIL] %s %s expected %b actual %b", cur_test, what, exp, act));
		end
	endtask

	////////////////////
	// bus access

	task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
		@(posedge clk_sys);
		bus_wr    <= 1'b1;
		bus_addr  <= addr;
		bus_wdata <= data;
		@(posedge clk_sys);	// write edge
		bus_wr    <= 1'b0;
		bus_addr  <= '0;
		bus_wdata <= '0;
	endtask

	task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
		@(posedge clk_sys);
		bus_rd   <= 1'b1;
		bus_addr <= addr;
		@(negedge clk_sys);
		data = bus_rdata;
		@(posedge clk_sys);
		bus_rd   <= 1'b0;
		bus_addr <= '0;
	endtask

	////////////////////
	// tests

	task automatic test_reset();
		cur_test = "reset";
		repeat (RESET_CYCLES) @(posedge clk_sys);
		cpu_rst  <= 1'b1;
		bus_rd   <= 1'b1;
		bus_addr <= OPT_ADDR;
		@(negedge clk_sys);	// last reset edge has just passed
		check_data("rdata", '0, bus_rdata);
		check_joy("joy1", 16'hFFFF, joy1);
		check_joy("joy2", 16'hFFFF, joy2);
		check_bit("cyc", 1'b0, cyc);
		check_bit("ph1", 1'b0, ph1);
		check_bit("ph2", 1'b0, ph2);
		check_audio("audio", '0, audio);
		@(posedge clk_sys);
		bus_rd   <= 1'b0;
		bus_addr <= '0;
	endtask

	task automatic test_opts();
		bus_data_t wdata;
		bus_data_t rdata;
		bus_addr_t other;
		cur_test = "opt_reg";
		for (int i = 0; i < OPT_WRITES; i++) begin
			wdata = $urandom;
			other = OPT_ADDR ^ ($urandom | 32'd1);	// never the register address
			bus_write(OPT_ADDR, wdata);
			bus_read(OPT_ADDR, rdata);
			check_data("readback", wdata & OPT_MASK, rdata);
			bus_write(other, ~wdata);
			bus_read(other, rdata);
			check_data("other address", '0, rdata);
			bus_read(OPT_ADDR, rdata);
			check_data("kept", wdata & OPT_MASK, rdata);
		end
		bus_write(OPT_ADDR, '0);
	endtask

	task automatic test_joy();
		cont_key_t k1;
		cont_key_t k2;
		cont_key_t p1;
		cont_key_t p2;
		cur_test = "joy_map";
		p1 = '0;
		p2 = '0;
		for (int i = 0; i < JOY_KEYS; i++) begin
			k1 = $urandom;
			k2 = $urandom;
			@(posedge clk_sys);
			cont1_key <= k1;
			cont2_key <= k2;
			repeat (2) @(posedge clk_sys);
			@(negedge clk_sys);
			check_joy("joy1 old", joy_word(p1, 1'b0), joy1);	// still in the synchroniser
			check_joy("joy2 old", joy_word(p2, 1'b0), joy2);
			@(posedge clk_sys);
			@(negedge clk_sys);
			check_joy("joy1 new", joy_word(k1, 1'b0), joy1);
			check_joy("joy2 new", joy_word(k2, 1'b0), joy2);
			p1 = k1;
			p2 = k2;
		end
		cur_test = "joy_off";
		bus_write(OPT_ADDR, JOY1_OFF);
		@(negedge clk_sys);
		check_joy("joy1", joy_word(p1, 1'b1), joy1);
		check_joy("joy2", joy_word(p2, 1'b0), joy2);
		bus_write(OPT_ADDR, JOY2_OFF);
		@(negedge clk_sys);
		check_joy("joy1", joy_word(p1, 1'b0), joy1);
		check_joy("joy2", joy_word(p2, 1'b1), joy2);
		bus_write(OPT_ADDR, '0);
	endtask

	task automatic test_phase();
		phase_div_t m_div;
		logic       m_c1q;
		logic       m_cyc;
		logic       m_ph1;
		logic       m_ph2;
		logic       c1_cur;
		logic       cyc_ok;
		logic       ph_ok;
		cur_test = "phase";
		m_cyc  = 1'b0;
		m_ph1  = 1'b0;
		m_ph2  = 1'b0;
		cyc_ok = 1'b0;
		ph_ok  = 1'b0;	// phases unknown until the first slot 2
		@(posedge clk_sys);
		c1 <= 1'b1;
		@(posedge clk_sys);	// rise seen, divider loads 3
		m_div = 4'd3;
		m_c1q = 1'b1;
		for (int i = 0; i < PHASE_CYCLES; i++) begin
			c1_cur = (i < 6) || (i >= 21 && i < 27);	// second rise lands mid frame
			c1 <= c1_cur;
			@(posedge clk_sys);
			m_cyc  = (m_div[1:0] == 2'd0);
			cyc_ok = 1'b1;
			if (m_div[1:0] == 2'd2) begin
				m_ph1 = (m_div[3:2] == 2'd2);
				m_ph2 = (m_div[3:2] == 2'd0);
				ph_ok = 1'b1;
			end
			if (c1_cur && !m_c1q) begin
				m_div = 4'd3;
			end else begin
				m_div = m_div + 1'b1;
			end
			m_c1q = c1_cur;
			@(negedge clk_sys);
			if (cyc_ok) begin
				check_bit("cyc", m_cyc, cyc);
			end
			if (ph_ok) begin
				check_bit("ph1", m_ph1, ph1);
				check_bit("ph2", m_ph2, ph2);
			end
		end
		c1 <= 1'b0;
	endtask

	task automatic test_audio();
		logic [31:0] rnd;
		logic [17:0] alt;
		stereo_raw_t r;
		stereo_pwm_t p;
		stereo_out_t prev;
		stereo_out_t want;
		cur_test = "audio_raw";
		prev = '0;
		for (int i = 0; i < AUDIO_SAMPLES; i++) begin
			rnd = $urandom;
			r = rnd[29:0];
			want = raw_form(r);
			@(posedge clk_sys);
			paula_raw <= r;
			repeat (3) @(posedge clk_sys);
			@(negedge clk_sys);
			check_audio("before settle", prev, audio);
			@(posedge clk_sys);
			@(negedge clk_sys);
			check_audio("settled", want, audio);
			prev = want;
		end
		cur_test = "audio_pwm";
		rnd = $urandom;
		p = rnd[17:0];
		want = pwm_form(p);
		@(posedge clk_sys);
		paula_okk <= p;
		bus_write(OPT_ADDR, PWM_ON);	// format switches after this edge
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		check_audio("before settle", prev, audio);
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_audio("settled", want, audio);
		prev = want;
		cur_test = "audio_toggle";
		rnd = $urandom;
		alt = rnd[17:0];
		for (int i = 0; i < TOGGLE_CYCLES; i++) begin
			@(posedge clk_sys);
			paula_okk <= i[0] ? ~alt : alt;	// differs from the last value every cycle
			@(negedge clk_sys);
			check_audio("held", prev, audio);
		end
	endtask

	////////////////////
	// main

	initial begin
		seed_val  = $urandom(RAND_SEED);
		err_count = 0;
		cur_test  = "init";
		clk_sys   = 1'b0;
		cpu_rst   = 1'b0;
		bus_wr    = 1'b0;
		bus_rd    = 1'b0;
		bus_addr  = '0;
		bus_wdata = '0;
		cont1_key = '0;
		cont2_key = '0;
		c1        = 1'b0;
		paula_raw = '0;
		paula_okk = '0;
		test_reset();
		test_opts();
		test_joy();
		test_phase();
		test_audio();
		if (err_count == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			abort_run("checks failed during the run");
		end
	end

	initial begin
		#(WATCHDOG_NS);
		abort_run("timeout, the tests did not finish within the cycle budget");
	end

endmodule

// ==== amiga_io_top.f ====
amiga_io_pkg.sv
core_opts_regs.sv
joy_mapper.sv
cpu_phase_gen.sv
paula_audio_out.sv
amiga_io_top.sv
tb_amiga_io_top.sv

// ==== Makefile ====
# Verilator flow for the clk_sys io glue

VERILATOR ?= verilator
TB_TOP    ?= tb_amiga_io_top
RTL_TOP   ?= amiga_io_top
FILELIST  ?= amiga_io_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= RESULT: PASS

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

# the run passes only when the pass line shows up
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
